/* common/dcache_pkg.sv */
`default_nettype none

package dcache_pkg;

  // ==================================================
  // cache geometry
  // ==================================================

  localparam int ADDR_W     = 32;
  localparam int LINE_BYTES = 32;
  localparam int WORD_BYTES = 8;
  localparam int N_SETS     = 64;
  localparam int N_WAYS     = 2;

  // address split: tag | index | offset
  localparam int OFFSET_W = $clog2(LINE_BYTES);
  localparam int INDEX_W  = $clog2(N_SETS);
  localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;

  // byte inside a word, word inside a line
  localparam int WORD_OFF_W = $clog2(WORD_BYTES);
  localparam int WORD_SEL_W = OFFSET_W - WORD_OFF_W;

  // replacement LFSR, 7 bits
  localparam logic [6:0] LFSR_SEED = 7'h03;

  // ==================================================
  // field types
  // ==================================================

  typedef logic [ADDR_W-1:0]         addr_t;
  typedef logic [TAG_W-1:0]          tag_t;
  typedef logic [INDEX_W-1:0]        index_t;
  typedef logic [WORD_BYTES*8-1:0]   word_t;
  typedef logic [WORD_BYTES-1:0]     wstrb_t;
  typedef logic [LINE_BYTES*8-1:0]   line_t;
  typedef logic [$clog2(N_WAYS)-1:0] way_t;

  // line state, MESI without Shared
  // exclusive is clean, modified is dirty
  typedef enum logic [1:0] {
    ST_INVALID   = 2'b00,
    ST_EXCLUSIVE = 2'b10,
    ST_MODIFIED  = 2'b11
  } line_state_t;

endpackage

`default_nettype wire

/* common/way_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface way_if;
  import dcache_pkg::*;

  // lookup and write request, from the controller
  logic              lookup;
  index_t            index;
  tag_t              tag;
  logic [N_WAYS-1:0] wr_en;
  line_state_t       wr_way_state;
  line_t             wr_line;

  // state sweep finished
  logic              ready;

  // lookup result, valid one cycle after lookup
  logic              hit;
  way_t              hit_way;
  line_t             rd_line;

  // replacement candidate of the looked-up set
  way_t              victim_way;
  line_state_t       victim_state;
  tag_t              victim_tag;
  line_t             victim_line;

  modport ctrl (
    output lookup, index, tag, wr_en, wr_way_state, wr_line,
    input  ready, hit, hit_way, rd_line,
    input  victim_way, victim_state, victim_tag, victim_line
  );

  modport ways (
    input  lookup, index, tag, wr_en, wr_way_state, wr_line,
    output ready, hit, hit_way, rd_line,
    output victim_way, victim_state, victim_tag, victim_line
  );

endinterface

`default_nettype wire

/* common/l2_req_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface l2_req_if;
  import dcache_pkg::*;

  // one-cycle pulse, fields sampled with it
  logic  start;
  // high for a line write-back, low for a fill
  logic  we;
  // line address, offset bits zero
  addr_t addr;
  // write-back payload
  line_t wline;

  // one-cycle pulse once the L2 handshake has closed
  logic  done;
  // fill data, held until the next start
  line_t rline;

  modport ctrl (
    output start,
    output we,
    output addr,
    output wline,
    input  done,
    input  rline
  );

  modport port (
    input  start,
    input  we,
    input  addr,
    input  wline,
    output done,
    output rline
  );

endinterface

`default_nettype wire

/* src/dc_ram.sv */
`timescale 1ns/10ps
`default_nettype none

// single-port array, registered read
module dc_ram #(
  parameter type entry_t = logic,
  parameter int  DEPTH   = 64
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               en_i,
  input  logic               we_i,
  input  dcache_pkg::index_t addr_i,
  input  entry_t             din_i,
  output entry_t             qout_o
);

  entry_t mem [DEPTH];

  // ==================================================
  // write port
  // ==================================================

  always_ff @(posedge clk) begin
    if (en_i && we_i) begin
      mem[addr_i] <= din_i;
    end
  end

  // ==================================================
  // read port
  // ==================================================

  // output holds its value across writes and idle cycles
  always_ff @(posedge clk) begin
    if (rst) begin
      qout_o <= entry_t'('0);
    end else if (en_i && !we_i) begin
      qout_o <= mem[addr_i];
    end
  end

endmodule

`default_nettype wire

/* dcache/dcache_ways.sv */
`timescale 1ns/10ps
`default_nettype none

module dcache_ways (
  input logic clk,
  input logic rst,
  way_if.ways ways
);
  import dcache_pkg::*;

  tag_t              tag_q   [N_WAYS];
  line_state_t       state_q [N_WAYS];
  line_t             data_q  [N_WAYS];
  tag_t              lk_tag_q;
  logic              lookup_q;
  logic              sweep_busy;
  index_t            sweep_idx;
  index_t            ram_addr;
  line_state_t       state_din;
  logic [6:0]        lfsr_q;
  logic [N_WAYS-1:0] match;
  logic              hit_c;
  way_t              hit_way_c;
  way_t              victim_c;

  // ==================================================
  // reset sweep of the state arrays
  // ==================================================

  always_ff @(posedge clk) begin
    if (rst) begin
      sweep_busy <= 1'b1;
      sweep_idx  <= '0;
    end else if (sweep_busy) begin
      sweep_idx <= sweep_idx + 1'b1;
      if (sweep_idx == index_t'(N_SETS - 1)) begin
        sweep_busy <= 1'b0;
      end
    end
  end

  assign ways.ready = ~sweep_busy;
  assign ram_addr   = sweep_busy ? sweep_idx : ways.index;
  assign state_din  = sweep_busy ? ST_INVALID : ways.wr_way_state;

  // ==================================================
  // arrays and tag compare
  // ==================================================

  for (genvar w = 0; w < N_WAYS; w++) begin : g_way
    dc_ram #(.entry_t(tag_t), .DEPTH(N_SETS)) u_tag (
      .clk (clk), .rst (rst),
      .en_i (ways.lookup | ways.wr_en[w]), .we_i (ways.wr_en[w]),
      .addr_i (ram_addr), .din_i (ways.tag), .qout_o (tag_q[w])
    );
    dc_ram #(.entry_t(line_state_t), .DEPTH(N_SETS)) u_state (
      .clk (clk), .rst (rst),
      .en_i (sweep_busy | ways.lookup | ways.wr_en[w]), .we_i (sweep_busy | ways.wr_en[w]),
      .addr_i (ram_addr), .din_i (state_din), .qout_o (state_q[w])
    );
    dc_ram #(.entry_t(line_t), .DEPTH(N_SETS)) u_data (
      .clk (clk), .rst (rst),
      .en_i (ways.lookup | ways.wr_en[w]), .we_i (ways.wr_en[w]),
      .addr_i (ram_addr), .din_i (ways.wr_line), .qout_o (data_q[w])
    );
    assign match[w] = (state_q[w] != ST_INVALID) && (tag_q[w] == lk_tag_q);
  end

  // tag of the lookup, compared one cycle later
  always_ff @(posedge clk) begin
    if (ways.lookup) begin
      lk_tag_q <= ways.tag;
    end
  end

  // lowest matching way
  always_comb begin
    hit_way_c = '0;
    for (int w = N_WAYS - 1; w >= 0; w--) begin
      if (match[w]) begin
        hit_way_c = way_t'(w);
      end
    end
  end

  assign hit_c        = |match;
  assign ways.hit     = hit_c;
  assign ways.hit_way = hit_way_c;
  assign ways.rd_line = data_q[hit_way_c];

  // ==================================================
  // victim choice
  // ==================================================

  // lowest invalid way first, LFSR otherwise
  always_comb begin
    victim_c = way_t'(lfsr_q[0]);
    for (int w = N_WAYS - 1; w >= 0; w--) begin
      if (state_q[w] == ST_INVALID) begin
        victim_c = way_t'(w);
      end
    end
  end

  // steps once per missing lookup
  always_ff @(posedge clk) begin
    if (rst) begin
      lookup_q <= 1'b0;
      lfsr_q   <= LFSR_SEED;
    end else begin
      lookup_q <= ways.lookup;
      if (lookup_q && !hit_c) begin
        lfsr_q <= {lfsr_q[5:0], lfsr_q[6] ^ lfsr_q[5]};
      end
    end
  end

  assign ways.victim_way   = victim_c;
  assign ways.victim_state = state_q[victim_c];
  assign ways.victim_tag   = tag_q[victim_c];
  assign ways.victim_line  = data_q[victim_c];

endmodule

`default_nettype wire

/* dcache/dcache_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module dcache_ctrl (
  input  logic               clk,
  input  logic               rst,
  input  logic               cpu_req_i,
  input  logic               cpu_we_i,
  input  dcache_pkg::addr_t  cpu_addr_i,
  input  dcache_pkg::word_t  cpu_wdata_i,
  input  dcache_pkg::wstrb_t cpu_be_i,
  output logic               cpu_ack_o,
  output dcache_pkg::word_t  cpu_rdata_o,
  output logic               cpu_miss_o,
  way_if.ctrl                ways,
  l2_req_if.ctrl             l2
);
  import dcache_pkg::*;

  typedef enum logic [2:0] {
    IDLE, LOOKUP, WRITEBACK, FILL, UPDATE, ACK
  } ctrl_state_t;

  ctrl_state_t           state_q;
  addr_t                 req_addr_q;
  logic                  req_we_q;
  word_t                 req_wdata_q;
  wstrb_t                req_be_q;
  logic                  miss_q;
  way_t                  tgt_way_q;
  logic                  accept;
  index_t                req_index;
  tag_t                  req_tag;
  logic [WORD_SEL_W-1:0] word_sel;
  line_t                 src_line;
  line_t                 new_line;
  addr_t                 wb_addr;
  addr_t                 fill_addr;

  assign accept    = (state_q == IDLE) && ways.ready && cpu_req_i;
  assign req_index = req_addr_q[OFFSET_W +: INDEX_W];
  assign req_tag   = req_addr_q[ADDR_W-1 -: TAG_W];
  assign word_sel  = req_addr_q[WORD_OFF_W +: WORD_SEL_W];

  // ==================================================
  // access FSM
  // ==================================================

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q   <= IDLE;
      miss_q    <= 1'b0;
      tgt_way_q <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          if (accept) begin
            miss_q  <= 1'b0;
            state_q <= LOOKUP;
          end
        end
        LOOKUP: begin
          tgt_way_q <= ways.hit ? ways.hit_way : ways.victim_way;
          if (ways.hit) begin
            state_q <= UPDATE;
          end else begin
            miss_q  <= 1'b1;
            state_q <= (ways.victim_state == ST_MODIFIED) ? WRITEBACK : FILL;
          end
        end
        WRITEBACK: if (l2.done) state_q <= FILL;
        FILL:      if (l2.done) state_q <= UPDATE;
        UPDATE:    state_q <= ACK;
        ACK:       if (!cpu_req_i) state_q <= IDLE;
        default:   state_q <= IDLE;
      endcase
    end
  end

  // access fields, held for the whole access
  always_ff @(posedge clk) begin
    if (accept) begin
      req_addr_q  <= cpu_addr_i;
      req_we_q    <= cpu_we_i;
      req_wdata_q <= cpu_wdata_i;
      req_be_q    <= cpu_be_i;
    end
  end

  // ==================================================
  // array side
  // ==================================================

  // way rd_line holds after the lookup, l2 rline holds after the fill
  assign src_line = miss_q ? l2.rline : ways.rd_line;

  // byte-enabled store merge
  always_comb begin
    new_line = src_line;
    for (int b = 0; b < WORD_BYTES; b++) begin
      if (req_we_q && req_be_q[b]) begin
        new_line[(int'(word_sel) * WORD_BYTES + b) * 8 +: 8] = req_wdata_q[b*8 +: 8];
      end
    end
  end

  // lookup goes out straight from the cpu fields
  assign ways.lookup = accept;
  assign ways.index  = (state_q == IDLE) ? cpu_addr_i[OFFSET_W +: INDEX_W] : req_index;
  assign ways.tag    = (state_q == IDLE) ? cpu_addr_i[ADDR_W-1 -: TAG_W] : req_tag;

  // load hit leaves the line alone, silent E to M on store hit
  always_comb begin
    for (int w = 0; w < N_WAYS; w++) begin
      ways.wr_en[w] = (state_q == UPDATE) && (req_we_q || miss_q) && (tgt_way_q == way_t'(w));
    end
  end

  assign ways.wr_way_state = req_we_q ? ST_MODIFIED : ST_EXCLUSIVE;
  assign ways.wr_line      = new_line;

  // ==================================================
  // l2 side
  // ==================================================

  assign wb_addr   = {ways.victim_tag, req_index, {OFFSET_W{1'b0}}};
  assign fill_addr = {req_tag, req_index, {OFFSET_W{1'b0}}};

  // fill goes out right after the write-back closes
  assign l2.start = ((state_q == LOOKUP) && !ways.hit) || ((state_q == WRITEBACK) && l2.done);
  assign l2.we    = (state_q == LOOKUP) && (ways.victim_state == ST_MODIFIED);
  assign l2.addr  = l2.we ? wb_addr : fill_addr;
  assign l2.wline = ways.victim_line;

  // cpu response
  assign cpu_ack_o   = (state_q == ACK);
  assign cpu_miss_o  = (state_q == ACK) && miss_q;
  assign cpu_rdata_o = src_line[int'(word_sel) * $bits(word_t) +: $bits(word_t)];

endmodule

`default_nettype wire

/* dcache/l2_port.sv */
`timescale 1ns/10ps
`default_nettype none

module l2_port (
  input  logic              clk,
  input  logic              rst,
  l2_req_if.port            l2,
  output logic              l2_req_o,
  output logic              l2_we_o,
  output dcache_pkg::addr_t l2_addr_o,
  output dcache_pkg::line_t l2_wdata_o,
  input  logic              l2_ack_i,
  input  dcache_pkg::line_t l2_rdata_i
);
  import dcache_pkg::*;

  typedef enum logic [1:0] {
    P_IDLE, P_REQ, P_DROP
  } port_state_t;

  port_state_t state_q;
  logic        done_q;
  line_t       rline_q;

  // ==================================================
  // four-phase sequence
  // ==================================================

  // req up, wait for ack, req down, wait for ack low
  always_ff @(posedge clk) begin
    if (rst) begin
      state_q  <= P_IDLE;
      l2_req_o <= 1'b0;
      l2_we_o  <= 1'b0;
      done_q   <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        P_IDLE: begin
          if (l2.start) begin
            l2_req_o <= 1'b1;
            l2_we_o  <= l2.we;
            state_q  <= P_REQ;
          end
        end
        P_REQ: begin
          if (l2_ack_i) begin
            l2_req_o <= 1'b0;
            state_q  <= P_DROP;
          end
        end
        P_DROP: begin
          if (!l2_ack_i) begin
            done_q  <= 1'b1;
            state_q <= P_IDLE;
          end
        end
        default: state_q <= P_IDLE;
      endcase
    end
  end

  // transfer payload
  always_ff @(posedge clk) begin
    if ((state_q == P_IDLE) && l2.start) begin
      l2_addr_o  <= l2.addr;
      l2_wdata_o <= l2.wline;
    end
    if ((state_q == P_REQ) && l2_ack_i) begin
      rline_q <= l2_rdata_i;
    end
  end

  assign l2.done  = done_q;
  assign l2.rline = rline_q;

endmodule

`default_nettype wire

/* src/dcache_top.sv */
`timescale 1ns/10ps
`default_nettype none

module dcache_top (
  input  logic               clk,
  input  logic               rst,
  // cpu side, four-phase
  input  logic               cpu_req_i,
  input  logic               cpu_we_i,
  input  dcache_pkg::addr_t  cpu_addr_i,
  input  dcache_pkg::word_t  cpu_wdata_i,
  input  dcache_pkg::wstrb_t cpu_be_i,
  output logic               cpu_ack_o,
  output dcache_pkg::word_t  cpu_rdata_o,
  output logic               cpu_miss_o,
  // l2 side, four-phase, whole lines
  output logic               l2_req_o,
  output logic               l2_we_o,
  output dcache_pkg::addr_t  l2_addr_o,
  output dcache_pkg::line_t  l2_wdata_o,
  input  logic               l2_ack_i,
  input  dcache_pkg::line_t  l2_rdata_i
);

  way_if    u_way_bus ();
  l2_req_if u_l2_bus ();

  dcache_ctrl u_ctrl (
    .clk         (clk),
    .rst         (rst),
    .cpu_req_i   (cpu_req_i),
    .cpu_we_i    (cpu_we_i),
    .cpu_addr_i  (cpu_addr_i),
    .cpu_wdata_i (cpu_wdata_i),
    .cpu_be_i    (cpu_be_i),
    .cpu_ack_o   (cpu_ack_o),
    .cpu_rdata_o (cpu_rdata_o),
    .cpu_miss_o  (cpu_miss_o),
    .ways        (u_way_bus.ctrl),
    .l2          (u_l2_bus.ctrl)
  );

  dcache_ways u_ways (
    .clk  (clk),
    .rst  (rst),
    .ways (u_way_bus.ways)
  );

  l2_port u_l2_port (
    .clk        (clk),
    .rst        (rst),
    .l2         (u_l2_bus.port),
    .l2_req_o   (l2_req_o),
    .l2_we_o    (l2_we_o),
    .l2_addr_o  (l2_addr_o),
    .l2_wdata_o (l2_wdata_o),
    .l2_ack_i   (l2_ack_i),
    .l2_rdata_i (l2_rdata_i)
  );

endmodule

`default_nettype wire

/* sim/dcache_asserts.sv */
`timescale 1ns/10ps
`default_nettype none

// handshake rules of both ports, output state after reset
module dcache_asserts (
  input logic              clk,
  input logic              rst,
  input logic              cpu_req_i,
  input logic              cpu_ack_o,
  input logic              cpu_miss_o,
  input logic              l2_req_o,
  input logic              l2_we_o,
  input dcache_pkg::addr_t l2_addr_o,
  input logic              l2_ack_i
);

  // failed properties so far
  int n_fail = 0;

  // ==================================================
  // cpu port
  // ==================================================

  a_cpu_req_rise: assert property (@(posedge clk) disable iff (rst)
    $rose(cpu_req_i) |-> !cpu_ack_o)
  else begin
    n_fail++;
    $error("cpu req rose while ack high");
  end
  a_cpu_req_hold: assert property (@(posedge clk) disable iff (rst)
    cpu_req_i && !cpu_ack_o |=> cpu_req_i)
  else begin
    n_fail++;
    $error("cpu req dropped before ack");
  end
  a_cpu_ack_drop: assert property (@(posedge clk) disable iff (rst)
    cpu_ack_o && !cpu_req_i |=> !cpu_ack_o)
  else begin
    n_fail++;
    $error("cpu ack held after req fell");
  end
  // ack and its miss flag hold until the requester lets go
  a_cpu_ack_hold: assert property (@(posedge clk) disable iff (rst)
    cpu_ack_o && cpu_req_i |=> cpu_ack_o && $stable(cpu_miss_o))
  else begin
    n_fail++;
    $error("cpu ack or miss flag changed while req high");
  end

  // ==================================================
  // l2 port
  // ==================================================

  a_l2_req_rise: assert property (@(posedge clk) disable iff (rst)
    $rose(l2_req_o) |-> !l2_ack_i)
  else begin
    n_fail++;
    $error("l2 req rose while ack high");
  end
  a_l2_req_hold: assert property (@(posedge clk) disable iff (rst)
    l2_req_o && !l2_ack_i |=> l2_req_o && $stable(l2_addr_o) && $stable(l2_we_o))
  else begin
    n_fail++;
    $error("l2 req or its fields changed before ack");
  end
  a_l2_req_drop: assert property (@(posedge clk) disable iff (rst)
    l2_req_o && l2_ack_i |=> !l2_req_o)
  else begin
    n_fail++;
    $error("l2 req held after ack");
  end

  a_reset_outputs: assert property (@(posedge clk)
    rst |=> !cpu_ack_o && !cpu_miss_o && !l2_req_o && !l2_we_o)
  else begin
    n_fail++;
    $error("control output high after reset");
  end

endmodule

bind dcache_top dcache_asserts u_asserts (
  .clk (clk), .rst (rst),
  .cpu_req_i (cpu_req_i), .cpu_ack_o (cpu_ack_o), .cpu_miss_o (cpu_miss_o),
  .l2_req_o (l2_req_o), .l2_we_o (l2_we_o), .l2_addr_o (l2_addr_o), .l2_ack_i (l2_ack_i)
);

`default_nettype wire

/* sim/tb_dcache.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_dcache;
  import dcache_pkg::*;

  localparam int N_ACCESSES     = 400;
  localparam int TIMEOUT_CYCLES = N_ACCESSES * 60;
  // req sampled one edge after it is driven, ack 2 cycles later, seen at the next edge
  localparam int HIT_EDGES      = 1 + 2 + 1;
  localparam int K_DATA         = 0;
  localparam int K_MISS         = 1;
  localparam int K_TIMING       = 2;
  localparam int K_L2           = 3;

  logic       clk = 1'b0;
  logic       rst;
  logic       cpu_req;
  logic       cpu_we;
  addr_t      cpu_addr;
  word_t      cpu_wdata;
  wstrb_t     cpu_be;
  logic       cpu_ack;
  word_t      cpu_rdata;
  logic       cpu_miss;
  logic       l2_req;
  logic       l2_we;
  addr_t      l2_addr;
  line_t      l2_wdata;
  logic       l2_ack;
  line_t      l2_rdata;

  int         cycles = 0;
  int         err_cnt [4];
  logic [7:0] ref_mem [addr_t];
  line_t      l2_mem [addr_t];
  addr_t      wr_addrs [$];
  line_t      wr_lines [$];
  addr_t      rd_addrs [$];
  // reference tag store, one LFSR for the whole cache
  tag_t       ref_tag   [N_SETS][N_WAYS];
  logic       ref_valid [N_SETS][N_WAYS];
  logic       ref_dirty [N_SETS][N_WAYS];
  logic [6:0] ref_lfsr;
  tag_t       tag_pool [4] = '{21'h00001, 21'h0abcd, 21'h15555, 21'h1f00f};
  index_t     idx_pool [3] = '{6'd0, 6'd17, 6'd63};

  always #4 clk = ~clk;

  dcache_top dut0 (
    .clk (clk), .rst (rst),
    .cpu_req_i (cpu_req), .cpu_we_i (cpu_we), .cpu_addr_i (cpu_addr),
    .cpu_wdata_i (cpu_wdata), .cpu_be_i (cpu_be), .cpu_ack_o (cpu_ack),
    .cpu_rdata_o (cpu_rdata), .cpu_miss_o (cpu_miss),
    .l2_req_o (l2_req), .l2_we_o (l2_we), .l2_addr_o (l2_addr),
    .l2_wdata_o (l2_wdata), .l2_ack_i (l2_ack), .l2_rdata_i (l2_rdata)
  );

  // ==================================================
  // memory contents
  // ==================================================

  function automatic logic [7:0] fill_pattern(input addr_t a);
    return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'ha5;
  endfunction

  function automatic logic [7:0] stored_byte(input addr_t a);
    if (ref_mem.exists(a)) begin
      return ref_mem[a];
    end
    return fill_pattern(a);
  endfunction

  function automatic line_t default_line(input addr_t base);
    line_t l;
    for (int b = 0; b < LINE_BYTES; b++) begin
      l[b*8 +: 8] = fill_pattern(base + addr_t'(b));
    end
    return l;
  endfunction

  function automatic line_t reference_line(input addr_t base);
    line_t l;
    for (int b = 0; b < LINE_BYTES; b++) begin
      l[b*8 +: 8] = stored_byte(base + addr_t'(b));
    end
    return l;
  endfunction

  function automatic logic [6:0] step_lfsr(input logic [6:0] v);
    return {v[5:0], v[6] ^ v[5]};
  endfunction

  task automatic record_mismatch(input int kind, input string msg);
    err_cnt[kind]++;
    $display("CHECK FAILED at %0t ns: %s", $time, msg);
  endtask

  task automatic print_summary();
    $display("errors: data %0d, miss flag %0d, hit timing %0d, l2 traffic %0d, protocol %0d",
             err_cnt[K_DATA], err_cnt[K_MISS], err_cnt[K_TIMING], err_cnt[K_L2],
             dut0.u_asserts.n_fail);
  endtask

  // ==================================================
  // L2 model, random response delay
  // ==================================================

  initial begin : l2_model
    int delay;
    l2_ack   <= 1'b0;
    l2_rdata <= '0;
    forever begin
      @(posedge clk);
      if (l2_req && !l2_ack) begin
        delay = int'($urandom_range(0, 6));
        repeat (delay) @(posedge clk);
        if (l2_we) begin
          wr_addrs.push_back(l2_addr);
          wr_lines.push_back(l2_wdata);
          l2_mem[l2_addr] = l2_wdata;
        end else begin
          rd_addrs.push_back(l2_addr);
          l2_rdata <= l2_mem.exists(l2_addr) ? l2_mem[l2_addr] : default_line(l2_addr);
        end
        l2_ack <= 1'b1;
        do begin
          @(posedge clk);
        end while (l2_req);
        l2_ack <= 1'b0;
      end
    end
  end

  // one cpu access, predicted from the reference tag store
  task automatic run_access(input logic we, input addr_t addr, input word_t wdata,
                            input wstrb_t be);
    index_t idx;
    tag_t   tag;
    logic   hit;
    int     way;
    logic   exp_wb;
    addr_t  wb_addr;
    line_t  wb_line;
    word_t  exp_word;
    int     edges;

    idx     = addr[OFFSET_W +: INDEX_W];
    tag     = addr[ADDR_W-1 -: TAG_W];
    hit     = 1'b0;
    way     = 0;
    exp_wb  = 1'b0;
    wb_addr = '0;
    wb_line = '0;
    for (int w = N_WAYS - 1; w >= 0; w--) begin
      if (ref_valid[idx][w] && ref_tag[idx][w] == tag) begin
        hit = 1'b1;
        way = w;
      end
    end
    if (!hit) begin
      // invalid way first, LFSR bit 0 otherwise
      way = int'(ref_lfsr[0]);
      for (int w = N_WAYS - 1; w >= 0; w--) begin
        if (!ref_valid[idx][w]) begin
          way = w;
        end
      end
      ref_lfsr = step_lfsr(ref_lfsr);
      exp_wb   = ref_valid[idx][way] && ref_dirty[idx][way];
      wb_addr  = {ref_tag[idx][way], idx, {OFFSET_W{1'b0}}};
      wb_line  = reference_line(wb_addr);
      ref_tag[idx][way]   = tag;
      ref_valid[idx][way] = 1'b1;
      ref_dirty[idx][way] = 1'b0;
    end
    ref_dirty[idx][way] = ref_dirty[idx][way] | we;
    for (int b = 0; b < WORD_BYTES; b++) begin
      exp_word[b*8 +: 8] = stored_byte(addr + addr_t'(b));
    end

    wr_addrs.delete();
    wr_lines.delete();
    rd_addrs.delete();
    cpu_req   <= 1'b1;
    cpu_we    <= we;
    cpu_addr  <= addr;
    cpu_wdata <= wdata;
    cpu_be    <= be;
    edges = 0;
    do begin
      @(posedge clk);
      edges++;
    end while (!cpu_ack);

    assert (cpu_miss == !hit) else
      record_mismatch(K_MISS, $sformatf("miss flag %0b at %h, expected %0b", cpu_miss, addr, !hit));
    if (hit) begin
      assert (edges == HIT_EDGES) else
        record_mismatch(K_TIMING, $sformatf("hit at %h acked after %0d edges", addr, edges));
    end
    if (!we) begin
      assert (cpu_rdata == exp_word) else
        record_mismatch(K_DATA, $sformatf("load %h gave %h, expected %h", addr, cpu_rdata,
                                          exp_word));
    end
    assert (rd_addrs.size() == (hit ? 0 : 1)) else
      record_mismatch(K_L2, $sformatf("%0d fills for access %h", rd_addrs.size(), addr));
    if (!hit && rd_addrs.size() == 1) begin
      assert (rd_addrs[0] == {tag, idx, {OFFSET_W{1'b0}}}) else
        record_mismatch(K_L2, $sformatf("fill address %h for access %h", rd_addrs[0], addr));
    end
    assert (wr_addrs.size() == (exp_wb ? 1 : 0)) else
      record_mismatch(K_L2, $sformatf("%0d write-backs for access %h", wr_addrs.size(), addr));
    if (exp_wb && wr_addrs.size() == 1) begin
      assert (wr_addrs[0] == wb_addr && wr_lines[0] == wb_line) else
        record_mismatch(K_L2, $sformatf("write-back to %h, expected %h", wr_addrs[0], wb_addr));
    end

    cpu_req <= 1'b0;
    for (int b = 0; b < WORD_BYTES; b++) begin
      if (we && be[b]) begin
        ref_mem[addr + addr_t'(b)] = wdata[b*8 +: 8];
      end
    end
    do begin
      @(posedge clk);
    end while (cpu_ack);
  endtask

  // ==================================================
  // stimulus
  // ==================================================

  initial begin : stimulus
    addr_t  addr;
    logic   we;
    wstrb_t be;
    int     total;
    void'($urandom(32'h439));
    rst       <= 1'b1;
    cpu_req   <= 1'b0;
    cpu_we    <= 1'b0;
    cpu_addr  <= '0;
    cpu_wdata <= '0;
    cpu_be    <= '0;
    ref_lfsr  = LFSR_SEED;
    foreach (err_cnt[k]) begin
      err_cnt[k] = 0;
    end
    for (int s = 0; s < N_SETS; s++) begin
      for (int w = 0; w < N_WAYS; w++) begin
        ref_tag[s][w]   = '0;
        ref_valid[s][w] = 1'b0;
        ref_dirty[s][w] = 1'b0;
      end
    end
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    // state sweep, one set per cycle
    repeat (N_SETS + 2) @(posedge clk);
    for (int i = 0; i < N_ACCESSES; i++) begin
      addr = {tag_pool[$urandom_range(0, 3)], idx_pool[$urandom_range(0, 2)],
              OFFSET_W'($urandom_range(0, 3) * WORD_BYTES)};
      we   = 1'($urandom_range(0, 1));
      be   = ($urandom_range(0, 3) == 0) ? 8'hff : 8'($urandom_range(1, 255));
      run_access(we, addr, {$urandom, $urandom}, be);
    end
    print_summary();
    total = err_cnt[K_DATA] + err_cnt[K_MISS] + err_cnt[K_TIMING] + err_cnt[K_L2]
            + dut0.u_asserts.n_fail;
    if (total == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == TIMEOUT_CYCLES) begin
      $display("timeout: the cache stopped answering after %0d cycles", cycles);
      print_summary();
      $display("TEST FAILED");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* sources.f */
common/dcache_pkg.sv
common/way_if.sv
common/l2_req_if.sv
src/dc_ram.sv
dcache/dcache_ways.sv
dcache/dcache_ctrl.sv
dcache/l2_port.sv
src/dcache_top.sv
sim/dcache_asserts.sv
sim/tb_dcache.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_dcache -f sources.f -o sim_dcache

if ! ./obj_dir/sim_dcache > sim.log 2>&1; then
  cat sim.log
  echo "simulation aborted"
  exit 1
fi
cat sim.log

if grep -q "TEST FAILED" sim.log; then
  exit 1
fi
exit 0
